/* rv32i_pkg.sv */
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111
    } rv32i_opcode_e;

    typedef enum logic [3:0] {
        add, sub, sll, slt, sltu, bxor, srl, sra, bor, band
    } alu_op_e;

    // encoded exactly as the branch funct3 field
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg rs2;
        rv32i_reg rs1;
        logic [2:0] funct3;
        rv32i_reg rd;
        rv32i_opcode_e opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        rv32i_reg rs1;
        logic [2:0] funct3;
        rv32i_reg rd;
        rv32i_opcode_e opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        rv32i_reg rs2;
        rv32i_reg rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        rv32i_opcode_e opcode;
    } s_type_t;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10_5;
        rv32i_reg rs2;
        rv32i_reg rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic imm11;
        rv32i_opcode_e opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        rv32i_reg rd;
        rv32i_opcode_e opcode;
    } u_type_t;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10_1;
        logic imm11;
        logic [7:0] imm19_12;
        rv32i_reg rd;
        rv32i_opcode_e opcode;
    } j_type_t;

    // one instruction word, six ways to read it
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        s_type_t s_type;
        b_type_t b_type;
        u_type_t u_type;
        j_type_t j_type;
    } rv32i_insn_u;

    typedef struct packed {
        alu_op_e alu_op;
        branch_funct3_e cmp_op;
        logic src_a_pc;
        logic src_b_imm;
        logic zero_a;
        logic is_branch;
        logic is_jump;
        logic jalr_align;
        logic link;
        logic reg_write;
    } ctrl_t;

endpackage

/* rv32i_dec_ex_if.sv */
`timescale 1ns/1ps

interface rv32i_dec_ex_if;
    logic valid;
    rv32i_pkg::rv32i_word pc;
    rv32i_pkg::ctrl_t ctrl;
    rv32i_pkg::rv32i_reg rs1;
    rv32i_pkg::rv32i_reg rs2;
    rv32i_pkg::rv32i_reg rd;
    rv32i_pkg::rv32i_word rs1_data;
    rv32i_pkg::rv32i_word rs2_data;
    rv32i_pkg::rv32i_word imm;

    // decode side
    modport source (output valid, pc, ctrl, rs1, rs2, rd, rs1_data, rs2_data, imm);

    // execute side
    modport sink (input valid, pc, ctrl, rs1, rs2, rd, rs1_data, rs2_data, imm);
endinterface

/* rv32i_ex_wb_if.sv */
`timescale 1ns/1ps

interface rv32i_ex_wb_if;
    // valid only for an actual register write
    logic valid;
    rv32i_pkg::rv32i_reg rd;
    rv32i_pkg::rv32i_word data;

    modport source (output valid, rd, data);
    modport sink (input valid, rd, data);
endinterface

/* rv32i_regfile.sv */
`timescale 1ns/1ps

module rv32i_regfile (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_we,
    input  rv32i_pkg::rv32i_reg  i_waddr,
    input  rv32i_pkg::rv32i_word i_wdata,
    input  rv32i_pkg::rv32i_reg  i_raddr_a,
    input  rv32i_pkg::rv32i_reg  i_raddr_b,
    output rv32i_pkg::rv32i_word o_rdata_a,
    output rv32i_pkg::rv32i_word o_rdata_b
);

    // x0 is not stored
    rv32i_pkg::rv32i_word regs [1:31];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // write-through so a same-cycle reader sees the new value
    always_comb begin
        if (i_raddr_a == '0) begin
            o_rdata_a = '0;
        end else if (i_we && (i_waddr == i_raddr_a)) begin
            o_rdata_a = i_wdata;
        end else begin
            o_rdata_a = regs[i_raddr_a];
        end
        if (i_raddr_b == '0) begin
            o_rdata_b = '0;
        end else if (i_we && (i_waddr == i_raddr_b)) begin
            o_rdata_b = i_wdata;
        end else begin
            o_rdata_b = regs[i_raddr_b];
        end
    end

endmodule

/* rv32i_decode.sv */
`timescale 1ns/1ps

module rv32i_decode #(
    parameter rv32i_pkg::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_stall,
    input  logic                 i_redirect,
    input  rv32i_pkg::rv32i_word i_redirect_pc,
    input  rv32i_pkg::rv32i_word i_i_rdata,
    output rv32i_pkg::rv32i_word o_i_addr,
    input  logic                 i_wb_we,
    input  rv32i_pkg::rv32i_reg  i_wb_rd,
    input  rv32i_pkg::rv32i_word i_wb_data,
    rv32i_dec_ex_if.source       dec_ex
);

    rv32i_pkg::rv32i_word pc_q;
    rv32i_pkg::rv32i_word ir_pc_q;
    rv32i_pkg::rv32i_insn_u ir_q;
    logic ir_valid_q;
    rv32i_pkg::ctrl_t ctrl;
    rv32i_pkg::rv32i_word imm;
    logic known;

    // alt is funct7[5], only meaningful as sub on register ops
    function automatic rv32i_pkg::alu_op_e alu_sel(input logic [2:0] funct3,
                                                   input logic alt,
                                                   input logic is_reg);
        rv32i_pkg::alu_op_e sel;
        case (funct3)
            3'b000:  sel = (alt && is_reg) ? rv32i_pkg::sub : rv32i_pkg::add;
            3'b001:  sel = rv32i_pkg::sll;
            3'b010:  sel = rv32i_pkg::slt;
            3'b011:  sel = rv32i_pkg::sltu;
            3'b100:  sel = rv32i_pkg::bxor;
            3'b101:  sel = alt ? rv32i_pkg::sra : rv32i_pkg::srl;
            3'b110:  sel = rv32i_pkg::bor;
            default: sel = rv32i_pkg::band;
        endcase
        return sel;
    endfunction

    assign o_i_addr = pc_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc_q <= RESET_PC;
            ir_valid_q <= 1'b0;
        end else if (!i_stall) begin
            pc_q <= i_redirect ? i_redirect_pc : pc_q + 32'd4;
            // fetched word is on the wrong path after a redirect
            ir_valid_q <= !i_redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            ir_q <= i_i_rdata;
            ir_pc_q <= pc_q;
        end
    end

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = rv32i_pkg::add;
        ctrl.cmp_op = rv32i_pkg::beq;
        imm = '0;
        known = 1'b1;
        case (ir_q.r_type.opcode)
            rv32i_pkg::op: begin
                ctrl.alu_op = alu_sel(ir_q.r_type.funct3, ir_q.r_type.funct7[5], 1'b1);
                ctrl.reg_write = 1'b1;
            end
            rv32i_pkg::op_imm: begin
                imm = {{20{ir_q.i_type.imm[11]}}, ir_q.i_type.imm};
                ctrl.alu_op = alu_sel(ir_q.i_type.funct3, ir_q.r_type.funct7[5], 1'b0);
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv32i_pkg::lui: begin
                imm = {ir_q.u_type.imm, 12'b0};
                ctrl.zero_a = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv32i_pkg::auipc: begin
                imm = {ir_q.u_type.imm, 12'b0};
                ctrl.src_a_pc = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv32i_pkg::branch: begin
                // alu forms the target, the comparator decides
                imm = {{19{ir_q.b_type.imm12}}, ir_q.b_type.imm12, ir_q.b_type.imm11,
                       ir_q.b_type.imm10_5, ir_q.b_type.imm4_1, 1'b0};
                ctrl.cmp_op = rv32i_pkg::branch_funct3_e'(ir_q.b_type.funct3);
                ctrl.src_a_pc = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.is_branch = 1'b1;
            end
            rv32i_pkg::jal: begin
                imm = {{11{ir_q.j_type.imm20}}, ir_q.j_type.imm20, ir_q.j_type.imm19_12,
                       ir_q.j_type.imm11, ir_q.j_type.imm10_1, 1'b0};
                ctrl.src_a_pc = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.is_jump = 1'b1;
                ctrl.link = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv32i_pkg::jalr: begin
                imm = {{20{ir_q.i_type.imm[11]}}, ir_q.i_type.imm};
                ctrl.src_b_imm = 1'b1;
                ctrl.is_jump = 1'b1;
                ctrl.jalr_align = 1'b1;
                ctrl.link = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    rv32i_regfile regfile_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_we      (i_wb_we),
        .i_waddr   (i_wb_rd),
        .i_wdata   (i_wb_data),
        .i_raddr_a (ir_q.s_type.rs1),
        .i_raddr_b (ir_q.s_type.rs2),
        .o_rdata_a (dec_ex.rs1_data),
        .o_rdata_b (dec_ex.rs2_data)
    );

    // unknown opcodes leave as a bubble
    assign dec_ex.valid = ir_valid_q && known;
    assign dec_ex.pc = ir_pc_q;
    assign dec_ex.ctrl = ctrl;
    assign dec_ex.rs1 = ir_q.s_type.rs1;
    assign dec_ex.rs2 = ir_q.s_type.rs2;
    assign dec_ex.rd = ir_q.r_type.rd;
    assign dec_ex.imm = imm;

endmodule

/* rv32i_execute.sv */
`timescale 1ns/1ps

module rv32i_execute (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_stall,
    rv32i_dec_ex_if.sink         dec_ex,
    rv32i_ex_wb_if.source        ex_wb,
    input  logic                 i_fwd_we,
    input  rv32i_pkg::rv32i_reg  i_fwd_rd,
    input  rv32i_pkg::rv32i_word i_fwd_data,
    output logic                 o_redirect,
    output rv32i_pkg::rv32i_word o_redirect_pc
);

    logic valid_q;
    rv32i_pkg::rv32i_word pc_q;
    rv32i_pkg::ctrl_t ctrl_q;
    rv32i_pkg::rv32i_reg rs1_q;
    rv32i_pkg::rv32i_reg rs2_q;
    rv32i_pkg::rv32i_reg rd_q;
    rv32i_pkg::rv32i_word rs1_data_q;
    rv32i_pkg::rv32i_word rs2_data_q;
    rv32i_pkg::rv32i_word imm_q;

    rv32i_pkg::rv32i_word rs1_val;
    rv32i_pkg::rv32i_word rs2_val;
    rv32i_pkg::rv32i_word op_a;
    rv32i_pkg::rv32i_word op_b;
    rv32i_pkg::rv32i_word alu_out;
    logic taken;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (!i_stall) begin
            // squash the instruction behind a taken branch or jump
            valid_q <= dec_ex.valid && !o_redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            pc_q <= dec_ex.pc;
            ctrl_q <= dec_ex.ctrl;
            rs1_q <= dec_ex.rs1;
            rs2_q <= dec_ex.rs2;
            rd_q <= dec_ex.rd;
            rs1_data_q <= dec_ex.rs1_data;
            rs2_data_q <= dec_ex.rs2_data;
            imm_q <= dec_ex.imm;
        end
    end

    // bypass from the result stage
    assign rs1_val = (i_fwd_we && (rs1_q != '0) && (i_fwd_rd == rs1_q)) ? i_fwd_data : rs1_data_q;
    assign rs2_val = (i_fwd_we && (rs2_q != '0) && (i_fwd_rd == rs2_q)) ? i_fwd_data : rs2_data_q;

    always_comb begin
        if (ctrl_q.zero_a) begin
            op_a = '0;
        end else if (ctrl_q.src_a_pc) begin
            op_a = pc_q;
        end else begin
            op_a = rs1_val;
        end
        op_b = ctrl_q.src_b_imm ? imm_q : rs2_val;
    end

    always_comb begin
        case (ctrl_q.alu_op)
            rv32i_pkg::sub:  alu_out = op_a - op_b;
            rv32i_pkg::sll:  alu_out = op_a << op_b[4:0];
            rv32i_pkg::slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv32i_pkg::sltu: alu_out = {31'b0, op_a < op_b};
            rv32i_pkg::bxor: alu_out = op_a ^ op_b;
            rv32i_pkg::srl:  alu_out = op_a >> op_b[4:0];
            rv32i_pkg::sra:  alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            rv32i_pkg::bor:  alu_out = op_a | op_b;
            rv32i_pkg::band: alu_out = op_a & op_b;
            default:         alu_out = op_a + op_b;
        endcase
    end

    // branch comparator works on the register values, never the immediate
    always_comb begin
        case (ctrl_q.cmp_op)
            rv32i_pkg::beq:  taken = rs1_val == rs2_val;
            rv32i_pkg::bne:  taken = rs1_val != rs2_val;
            rv32i_pkg::blt:  taken = $signed(rs1_val) < $signed(rs2_val);
            rv32i_pkg::bge:  taken = $signed(rs1_val) >= $signed(rs2_val);
            rv32i_pkg::bltu: taken = rs1_val < rs2_val;
            rv32i_pkg::bgeu: taken = rs1_val >= rs2_val;
            default:         taken = 1'b0;
        endcase
    end

    assign o_redirect = valid_q && (ctrl_q.is_jump || (ctrl_q.is_branch && taken));
    assign o_redirect_pc = ctrl_q.jalr_align ? {alu_out[31:1], 1'b0} : alu_out;

    // no write for branches or x0
    assign ex_wb.valid = valid_q && ctrl_q.reg_write && (rd_q != '0);
    assign ex_wb.rd = rd_q;
    assign ex_wb.data = ctrl_q.link ? pc_q + 32'd4 : alu_out;

endmodule

/* rv32i_result.sv */
`timescale 1ns/1ps

module rv32i_result (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_stall,
    rv32i_ex_wb_if.sink          ex_wb,
    output logic                 o_we,
    output rv32i_pkg::rv32i_reg  o_rd,
    output rv32i_pkg::rv32i_word o_data,
    output logic                 o_wb_valid,
    output rv32i_pkg::rv32i_reg  o_wb_rd,
    output rv32i_pkg::rv32i_word o_wb_data
);

    logic valid_q;
    rv32i_pkg::rv32i_reg rd_q;
    rv32i_pkg::rv32i_word data_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (!i_stall) begin
            valid_q <= ex_wb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            rd_q <= ex_wb.rd;
            data_q <= ex_wb.data;
        end
    end

    // a frozen pipeline must not write the same value twice
    assign o_we = valid_q && !i_stall;
    assign o_rd = rd_q;
    assign o_data = data_q;

    assign o_wb_valid = o_we;
    assign o_wb_rd = rd_q;
    assign o_wb_data = data_q;

endmodule

/* rv32i_core.sv */
`timescale 1ns/1ps

module rv32i_core #(
    parameter rv32i_pkg::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_stall,
    input  rv32i_pkg::rv32i_word i_i_rdata,
    output rv32i_pkg::rv32i_word o_i_addr,
    output logic                 o_wb_valid,
    output rv32i_pkg::rv32i_reg  o_wb_rd,
    output rv32i_pkg::rv32i_word o_wb_data
);

    logic redirect;
    rv32i_pkg::rv32i_word redirect_pc;
    logic wb_we;
    rv32i_pkg::rv32i_reg wb_rd;
    rv32i_pkg::rv32i_word wb_data;

    rv32i_dec_ex_if dec_ex ();
    rv32i_ex_wb_if ex_wb ();

    rv32i_decode #(
        .RESET_PC (RESET_PC)
    ) decode_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_stall       (i_stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_i_rdata     (i_i_rdata),
        .o_i_addr      (o_i_addr),
        .i_wb_we       (wb_we),
        .i_wb_rd       (wb_rd),
        .i_wb_data     (wb_data),
        .dec_ex        (dec_ex.source)
    );

    rv32i_execute execute_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_stall       (i_stall),
        .dec_ex        (dec_ex.sink),
        .ex_wb         (ex_wb.source),
        .i_fwd_we      (wb_we),
        .i_fwd_rd      (wb_rd),
        .i_fwd_data    (wb_data),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    rv32i_result result_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_stall    (i_stall),
        .ex_wb      (ex_wb.sink),
        .o_we       (wb_we),
        .o_rd       (wb_rd),
        .o_data     (wb_data),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

/* tb_rv32i_core.sv */
`timescale 1ns/1ps

module tb_rv32i_core;

    localparam rv32i_pkg::rv32i_word RESET_PC = 32'h0000_0100;
    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MODEL_STEPS = 500;

    logic clk;
    logic rst;
    logic stall;
    rv32i_pkg::rv32i_word i_rdata;
    rv32i_pkg::rv32i_word i_addr;
    logic wb_valid;
    rv32i_pkg::rv32i_reg wb_rd;
    rv32i_pkg::rv32i_word wb_data;

    rv32i_pkg::rv32i_word imem [MEM_WORDS];
    rv32i_pkg::rv32i_word prog [$];
    rv32i_pkg::rv32i_word alu_prog [$];
    rv32i_pkg::rv32i_reg exp_rd [$];
    rv32i_pkg::rv32i_word exp_data [$];
    rv32i_pkg::rv32i_word exp_targets [$];
    int value_errors = 0;
    int other_errors = 0;

    tb_clock #(
        .PERIOD_NS (100)
    ) clock_i (
        .o_clk (clk)
    );

    rv32i_core #(
        .RESET_PC (RESET_PC)
    ) rv32i_core_i (
        .clk        (clk),
        .i_rst      (rst),
        .i_stall    (stall),
        .i_i_rdata  (i_rdata),
        .o_i_addr   (i_addr),
        .o_wb_valid (wb_valid),
        .o_wb_rd    (wb_rd),
        .o_wb_data  (wb_data)
    );

    // instruction memory answers in the same cycle
    assign i_rdata = (i_addr < 4 * MEM_WORDS) ? imem[i_addr[9:2]] : '0;

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected valid %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_reg(input string name, input rv32i_pkg::rv32i_reg exp,
                               input rv32i_pkg::rv32i_reg act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected rd x%0d, actual x%0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_word(input string name, input rv32i_pkg::rv32i_word exp,
                                input rv32i_pkg::rv32i_word act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    // instruction encoders
    function automatic rv32i_pkg::rv32i_word enc_r(input logic [6:0] f7,
                                                   input rv32i_pkg::rv32i_reg rs2,
                                                   input rv32i_pkg::rv32i_reg rs1,
                                                   input logic [2:0] f3,
                                                   input rv32i_pkg::rv32i_reg rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv32i_pkg::rv32i_word enc_i(input logic [11:0] imm,
                                                   input rv32i_pkg::rv32i_reg rs1,
                                                   input logic [2:0] f3,
                                                   input rv32i_pkg::rv32i_reg rd,
                                                   input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv32i_pkg::rv32i_word enc_u(input logic [19:0] imm,
                                                   input rv32i_pkg::rv32i_reg rd,
                                                   input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv32i_pkg::rv32i_word enc_b(input logic [12:0] imm,
                                                   input rv32i_pkg::rv32i_reg rs2,
                                                   input rv32i_pkg::rv32i_reg rs1,
                                                   input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv32i_pkg::rv32i_word enc_j(input logic [20:0] imm,
                                                   input rv32i_pkg::rv32i_reg rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input rv32i_pkg::rv32i_word w);
        prog.push_back(w);
    endtask

    // lui plus addi, upper part rounded for the sign of the low part
    task automatic load_const(input rv32i_pkg::rv32i_reg rd, input rv32i_pkg::rv32i_word v);
        rv32i_pkg::rv32i_word hi;
        hi = (v + 32'h800) >> 12;
        emit(enc_u(hi[19:0], rd, rv32i_pkg::lui));
        emit(enc_i(v[11:0], rd, 3'd0, rd, rv32i_pkg::op_imm));
    endtask

    // program ends in a jump to itself
    task automatic finish_program();
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
        end
        foreach (prog[i]) begin
            imem[RESET_PC[9:2] + i] = prog[i];
        end
    endtask

    function automatic rv32i_pkg::rv32i_word fetch_word(input rv32i_pkg::rv32i_word pc);
        return (pc < 4 * MEM_WORDS) ? imem[pc[9:2]] : '0;
    endfunction

    function automatic rv32i_pkg::rv32i_word alu_ref(input logic [2:0] f3, input logic alt,
                                                     input rv32i_pkg::rv32i_word a,
                                                     input rv32i_pkg::rv32i_word b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input rv32i_pkg::rv32i_word a,
                                        input rv32i_pkg::rv32i_word b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // ISA model over the loaded program, builds expected writes and redirect targets
    task automatic run_model();
        rv32i_pkg::rv32i_word regs [32];
        rv32i_pkg::rv32i_word pc;
        rv32i_pkg::rv32i_word insn;
        rv32i_pkg::rv32i_word a;
        rv32i_pkg::rv32i_word b;
        rv32i_pkg::rv32i_word res;
        rv32i_pkg::rv32i_word next_pc;
        rv32i_pkg::rv32i_word imm_i;
        rv32i_pkg::rv32i_word imm_b;
        rv32i_pkg::rv32i_word imm_j;
        logic wr;
        logic stop;
        int steps;
        exp_rd.delete();
        exp_data.delete();
        exp_targets.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc = RESET_PC;
        stop = 1'b0;
        steps = 0;
        while (!stop && steps < MODEL_STEPS) begin
            insn = fetch_word(pc);
            a = regs[insn[19:15]];
            b = regs[insn[24:20]];
            imm_i = {{20{insn[31]}}, insn[31:20]};
            imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            next_pc = pc + 32'd4;
            res = '0;
            wr = 1'b1;
            case (insn[6:0])
                7'b0110011: res = alu_ref(insn[14:12], insn[30], a, b);
                7'b0010011: res = alu_ref(insn[14:12], insn[30] && (insn[14:12] == 3'd5),
                                          a, imm_i);
                7'b0110111: res = {insn[31:12], 12'b0};
                7'b0010111: res = pc + {insn[31:12], 12'b0};
                7'b1100011: begin
                    wr = 1'b0;
                    if (branch_ref(insn[14:12], a, b)) begin
                        next_pc = pc + imm_b;
                    end
                end
                7'b1101111: begin
                    res = pc + 32'd4;
                    next_pc = pc + imm_j;
                    stop = (imm_j == '0);
                end
                7'b1100111: begin
                    res = pc + 32'd4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && (insn[11:7] != 5'd0)) begin
                regs[insn[11:7]] = res;
                exp_rd.push_back(insn[11:7]);
                exp_data.push_back(res);
            end
            if (!stop && (next_pc != pc + 32'd4)) begin
                exp_targets.push_back(next_pc);
            end
            pc = next_pc;
            steps++;
        end
        if (!stop) begin
            $display("reference model never reached the closing loop");
            other_errors++;
        end
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        rst = 1'b1;
        stall = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
    endtask

    // called right at a rising edge, before any register updates
    task automatic sample_write(input string name, inout int idx);
        if (wb_valid && stall) begin
            $display("%s: write pulse while the pipeline was stalled", name);
            other_errors++;
        end
        if ((exp_targets.size() > 0) && (i_addr === exp_targets[0])) begin
            void'(exp_targets.pop_front());
        end
        if (wb_valid) begin
            if (idx >= exp_rd.size()) begin
                $display("%s: unexpected write of %h to x%0d", name, wb_data, wb_rd);
                other_errors++;
            end else begin
                compare_reg(name, exp_rd[idx], wb_rd);
                compare_word(name, exp_data[idx], wb_data);
            end
            idx++;
        end
    endtask

    task automatic run_and_check(input string name, input logic use_stall);
        int idx;
        int cycles;
        idx = 0;
        cycles = 0;
        load_program();
        run_model();
        pulse_reset();
        while ((idx < exp_rd.size()) && (cycles < TIMEOUT_CYCLES)) begin
            @(negedge clk);
            stall = use_stall ? ($urandom_range(2) == 0) : 1'b0;
            @(posedge clk);
            sample_write(name, idx);
            cycles++;
        end
        if (idx < exp_rd.size()) begin
            $display("%s: timed out with %0d of %0d writes seen", name, idx, exp_rd.size());
            other_errors++;
        end
        // a few idle cycles to catch late extra writes
        @(negedge clk);
        stall = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            sample_write(name, idx);
        end
        if (exp_targets.size() > 0) begin
            $display("%s: fetch address never reached target %h", name, exp_targets[0]);
            other_errors++;
        end
    endtask

    task automatic test_reset();
        prog.delete();
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, rv32i_pkg::op_imm));
        emit(enc_i(12'd7, 5'd1, 3'd0, 5'd2, rv32i_pkg::op_imm));
        finish_program();
        load_program();
        pulse_reset();
        compare_word("reset", RESET_PC, i_addr);
        // first write shows three cycles after the fetch
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            compare_bit("reset", 1'b0, wb_valid);
        end
        @(posedge clk);
        compare_bit("reset", 1'b1, wb_valid);
        compare_reg("reset", 5'd1, wb_rd);
        compare_word("reset", 32'd5, wb_data);
        @(posedge clk);
        compare_bit("reset", 1'b1, wb_valid);
        compare_reg("reset", 5'd2, wb_rd);
        compare_word("reset", 32'd12, wb_data);
    endtask

    // each op reads the last result and the one before it
    task automatic build_alu_program();
        logic [6:0] r_f7 [10];
        logic [2:0] r_f3 [10];
        rv32i_pkg::rv32i_reg rd;
        rv32i_pkg::rv32i_reg prev;
        rv32i_pkg::rv32i_reg prev2;
        logic [11:0] imm;
        logic [2:0] f3;
        prog.delete();
        r_f7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        r_f3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        for (int r = 1; r <= 4; r++) begin
            load_const(rv32i_pkg::rv32i_reg'(r), $urandom);
        end
        prev = 5'd1;
        prev2 = 5'd2;
        for (int i = 0; i < 10; i++) begin
            rd = rv32i_pkg::rv32i_reg'(5 + i % 8);
            emit(enc_r(r_f7[i], prev2, prev, r_f3[i], rd));
            prev2 = prev;
            prev = rd;
        end
        // immediate forms, the last one is srai
        for (int i = 0; i < 9; i++) begin
            rd = rv32i_pkg::rv32i_reg'(5 + (i + 2) % 8);
            imm = 12'($urandom);
            f3 = (i == 8) ? 3'd5 : 3'(i);
            if ((f3 == 3'd1) || (f3 == 3'd5)) begin
                imm = {(i == 8) ? 7'h20 : 7'h00, imm[4:0]};
            end
            emit(enc_i(imm, prev, f3, rd, rv32i_pkg::op_imm));
            prev = rd;
        end
        // x0 never written, always reads zero
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        emit(enc_r(7'h00, prev, 5'd0, 3'd0, 5'd13));
        emit(enc_r(7'h20, 5'd0, 5'd13, 3'd0, 5'd14));
        finish_program();
    endtask

    task automatic test_alu();
        build_alu_program();
        alu_prog = prog;
        run_and_check("alu", 1'b0);
    endtask

    task automatic test_upper();
        prog.delete();
        emit(enc_u(20'($urandom), 5'd6, rv32i_pkg::lui));
        emit(enc_u(20'($urandom), 5'd7, rv32i_pkg::auipc));
        emit(enc_u(20'hfffff, 5'd8, rv32i_pkg::auipc));
        emit(enc_r(7'h00, 5'd6, 5'd7, 3'd0, 5'd9));
        emit(enc_u(20'($urandom), 5'd0, rv32i_pkg::lui));
        finish_program();
        run_and_check("upper", 1'b0);
    endtask

    // taken and not taken per condition, on sign and magnitude edges
    task automatic test_branches();
        logic [2:0] f3 [12];
        rv32i_pkg::rv32i_reg ra [12];
        rv32i_pkg::rv32i_reg rb [12];
        prog.delete();
        f3 = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4, 3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
        ra = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd3, 5'd3, 5'd1, 5'd2, 5'd3, 5'd3, 5'd4};
        rb = '{5'd5, 5'd2, 5'd2, 5'd5, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd4, 5'd4, 5'd3};
        emit(enc_u(20'h80000, 5'd1, rv32i_pkg::lui));
        emit(enc_u(20'h80000, 5'd2, rv32i_pkg::lui));
        emit(enc_i(12'hfff, 5'd2, 3'd0, 5'd2, rv32i_pkg::op_imm));
        emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd3, rv32i_pkg::op_imm));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd4, rv32i_pkg::op_imm));
        emit(enc_r(7'h00, 5'd0, 5'd1, 3'd0, 5'd5));
        for (int i = 0; i < 12; i++) begin
            emit(enc_b(13'd12, rb[i], ra[i], f3[i]));
            emit(enc_i(12'(i + 32), 5'd0, 3'd0, 5'd10, rv32i_pkg::op_imm));
            emit(enc_i(12'(i + 64), 5'd0, 3'd0, 5'd11, rv32i_pkg::op_imm));
            emit(enc_i(12'(i), 5'd0, 3'd0, 5'd12, rv32i_pkg::op_imm));
        end
        finish_program();
        run_and_check("branches", 1'b0);
    endtask

    task automatic test_jumps();
        prog.delete();
        emit(enc_j(21'd12, 5'd1));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd10, rv32i_pkg::op_imm));
        emit(enc_i(12'd2, 5'd0, 3'd0, 5'd11, rv32i_pkg::op_imm));
        // odd jalr target, lands on word 8
        emit(enc_u(20'd0, 5'd2, rv32i_pkg::auipc));
        emit(enc_i(12'd19, 5'd2, 3'd0, 5'd2, rv32i_pkg::op_imm));
        emit(enc_i(12'd2, 5'd2, 3'd0, 5'd3, rv32i_pkg::jalr));
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd12, rv32i_pkg::op_imm));
        emit(enc_i(12'd4, 5'd0, 3'd0, 5'd13, rv32i_pkg::op_imm));
        emit(enc_i(12'd4, 5'd3, 3'd0, 5'd14, rv32i_pkg::op_imm));
        emit(enc_i(12'd44, 5'd1, 3'd0, 5'd15, rv32i_pkg::jalr));
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd16, rv32i_pkg::op_imm));
        emit(enc_i(12'd6, 5'd0, 3'd0, 5'd17, rv32i_pkg::op_imm));
        emit(enc_r(7'h00, 5'd14, 5'd15, 3'd0, 5'd18));
        finish_program();
        run_and_check("jumps", 1'b0);
    endtask

    task automatic test_stall();
        prog = alu_prog;
        run_and_check("stall", 1'b1);
    endtask

    initial begin
        void'($urandom(32'h93794aab));
        rst = 1'b1;
        stall = 1'b0;
        test_reset();
        test_alu();
        test_upper();
        test_branches();
        test_jumps();
        test_stall();
        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* build.f */
rv32i_pkg.sv
rv32i_dec_ex_if.sv
rv32i_ex_wb_if.sv
rv32i_regfile.sv
rv32i_decode.sv
rv32i_execute.sv
rv32i_result.sv
rv32i_core.sv
tb_clock.sv
tb_rv32i_core.sv

/* Bender.yml */
package:
  name: rv32i_core

sources:
  - rv32i_pkg.sv
  - rv32i_dec_ex_if.sv
  - rv32i_ex_wb_if.sv
  - rv32i_regfile.sv
  - rv32i_decode.sv
  - rv32i_execute.sv
  - rv32i_result.sv
  - rv32i_core.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_rv32i_core.sv
